// ==== verilog/video_timing_params.svh ====
`ifndef VIDEO_TIMING_PARAMS_SVH
`define VIDEO_TIMING_PARAMS_SVH

//////////////////////////////
// Raster geometry
//////////////////////////////

// 384 pixels per line, 264 lines per frame
`define H_LAST 9'd383
`define V_LAST 9'd263

//////////////////////////////
// Horizontal decode points
//////////////////////////////

`define HBLANK_START 9'd272
`define HBLANK_END 9'd368
`define HSYNC_START 9'd304
`define HSYNC_END 9'd336

//////////////////////////////
// Vertical decode points
//////////////////////////////

// Blank wraps through the frame end
`define VBLANK_START 9'd240
`define VBLANK_END 9'd16
`define VSYNC_START 9'd248
`define VSYNC_END 9'd0

// One-pixel strobes
`define HRESET_POS 9'd15
`define VRESET_POS 9'd304

`endif

// ==== verilog/video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

	// Pixel position within a line, 0 to 383
	typedef logic [8:0] hcount_t;

	// Line number within a frame, 0 to 263
	typedef logic [8:0] vcount_t;

	// Phase of the 48 MHz master divider
	typedef logic [2:0] div_count_t;

endpackage

`default_nettype wire

// ==== verilog/clock_enable_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_enable_gen (
	input wire CLK_48M,
	input wire rst,
	output logic clk_24m,
	output logic clk_12m,
	output logic clk_6m,
	output logic pix_en
);

	// Free running master phase
	video_timing_pkg::div_count_t div;

	//////////////////////////////
	// Master divider
	//////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			div <= '0;
		end else begin
			div <= div + 3'd1;
		end
	end

	// Divided clock levels straight off the counter bits
	assign clk_24m = div[0];
	assign clk_12m = div[1];
	assign clk_6m = div[2];

	//////////////////////////////
	// Pixel enable
	//////////////////////////////

	// Look one phase ahead so the register lines up with phase 7
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			pix_en <= 1'b0;
		end else begin
			pix_en <= (div == 3'd6);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/raster_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_params.svh"

module raster_counter (
	input wire CLK_48M,
	input wire rst,
	input wire pix_en,
	output video_timing_pkg::hcount_t hcount,
	output video_timing_pkg::vcount_t vcount
);

	// End of line and end of frame
	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hcount == `H_LAST);
	assign v_wrap = (vcount == `V_LAST);

	//////////////////////////////
	// Pixel counter
	//////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			hcount <= '0;
		end else if (pix_en) begin
			if (h_wrap) begin
				hcount <= '0;
			end else begin
				hcount <= hcount + 9'd1;
			end
		end
	end

	//////////////////////////////
	// Line counter
	//////////////////////////////

	// Steps only as the pixel counter wraps
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			vcount <= '0;
		end else if (pix_en && h_wrap) begin
			if (v_wrap) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 9'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sync_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_params.svh"

module sync_decoder (
	input wire CLK_48M,
	input wire rst,
	input wire pix_en,
	input wire video_timing_pkg::hcount_t hcount,
	input wire video_timing_pkg::vcount_t vcount,
	output logic hblank_n,
	output logic hsync_n,
	output logic vblank_n,
	output logic vsync_n
);

	// Vertical levels only move on the first pixel of a line
	logic line_start;

	assign line_start = (hcount == 9'd0);

	//////////////////////////////
	// Horizontal blank
	//////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			hblank_n <= 1'b1;
		end else if (pix_en) begin
			if (hcount == `HBLANK_START) begin
				hblank_n <= 1'b0;
			end else if (hcount == `HBLANK_END) begin
				hblank_n <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Horizontal sync
	//////////////////////////////

	// Sync pulse sits inside the blank window
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			hsync_n <= 1'b1;
		end else if (pix_en) begin
			if (hcount == `HSYNC_START) begin
				hsync_n <= 1'b0;
			end else if (hcount == `HSYNC_END) begin
				hsync_n <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Vertical blank and sync
	//////////////////////////////

	// Blank runs across the frame wrap, 240 round to 15
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			vblank_n <= 1'b1;
		end else if (pix_en && line_start) begin
			if (vcount == `VBLANK_START) begin
				vblank_n <= 1'b0;
			end else if (vcount == `VBLANK_END) begin
				vblank_n <= 1'b1;
			end
		end
	end

	// Released again on line 0
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			vsync_n <= 1'b1;
		end else if (pix_en && line_start) begin
			if (vcount == `VSYNC_START) begin
				vsync_n <= 1'b0;
			end else if (vcount == `VSYNC_END) begin
				vsync_n <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/timing_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_params.svh"

module timing_control (
	input wire CLK_48M,
	input wire rst,
	input wire pix_en,
	input wire video_timing_pkg::hcount_t hcount,
	input wire video_timing_pkg::vcount_t vcount,
	input wire hblank_n,
	input wire hsync_n,
	input wire vblank_n,
	input wire vsync_n,
	output logic n_hsync,
	output logic n_vsync,
	output logic n_hblank,
	output logic n_vblank,
	output logic n_hreset,
	output logic n_vreset,
	output logic clk_1h,
	output logic clk_s1h,
	output logic clk_2h,
	output logic clk_s2h,
	output logic clk_4h,
	output logic clk_1v,
	output logic clk_4v,
	output logic clk_8v
);

	// Single pixel strobes
	logic hreset_hit;
	logic vreset_hit;

	assign hreset_hit = (hcount == `HRESET_POS);
	assign vreset_hit = (vcount == 9'd0) && (hcount == `VRESET_POS);

	//////////////////////////////
	// Output registers
	//////////////////////////////

	// All board strobes change on one pixel edge
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			n_hsync <= 1'b1;
			n_vsync <= 1'b1;
			n_hblank <= 1'b1;
			n_vblank <= 1'b1;
			// Reset strobes idle low
			n_hreset <= 1'b0;
			n_vreset <= 1'b0;
			clk_1h <= 1'b0;
			clk_s1h <= 1'b0;
			clk_2h <= 1'b0;
			clk_s2h <= 1'b0;
			clk_4h <= 1'b0;
			clk_1v <= 1'b0;
			clk_4v <= 1'b0;
			clk_8v <= 1'b0;
		end else if (pix_en) begin
			// Second stage for the decoded levels
			n_hsync <= hsync_n;
			n_vsync <= vsync_n;
			n_hblank <= hblank_n;
			n_vblank <= vblank_n;
			n_hreset <= hreset_hit;
			n_vreset <= vreset_hit;
			// Counter taps, S copies in phase with the plain ones
			clk_1h <= hcount[0];
			clk_s1h <= hcount[0];
			clk_2h <= hcount[1];
			clk_s2h <= hcount[1];
			clk_4h <= hcount[2];
			clk_1v <= vcount[0];
			clk_4v <= vcount[3];
			clk_8v <= vcount[7];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/video_timing_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_timing_gen (
	input wire CLK_48M,
	input wire rst,
	output wire clk_24m,
	output wire clk_12m,
	output wire clk_6m,
	output wire n_hsync,
	output wire n_vsync,
	output wire n_hblank,
	output wire n_vblank,
	output wire n_hreset,
	output wire n_vreset,
	output wire clk_1h,
	output wire clk_s1h,
	output wire clk_2h,
	output wire clk_s2h,
	output wire clk_4h,
	output wire clk_1v,
	output wire clk_4v,
	output wire clk_8v
);

	// One pulse per pixel, every 8 master cycles
	wire pix_en;

	// Raster position
	wire video_timing_pkg::hcount_t hcount;
	wire video_timing_pkg::vcount_t vcount;

	// First stage sync and blank levels
	wire hblank_n;
	wire hsync_n;
	wire vblank_n;
	wire vsync_n;

	//////////////////////////////
	// Clocking and raster
	//////////////////////////////

	clock_enable_gen clk_gen0 (
		.CLK_48M(CLK_48M),
		.rst(rst),
		.clk_24m(clk_24m),
		.clk_12m(clk_12m),
		.clk_6m(clk_6m),
		.pix_en(pix_en)
	);

	raster_counter raster0 (
		.CLK_48M(CLK_48M),
		.rst(rst),
		.pix_en(pix_en),
		.hcount(hcount),
		.vcount(vcount)
	);

	//////////////////////////////
	// Decode and outputs
	//////////////////////////////

	sync_decoder sync0 (
		.CLK_48M(CLK_48M),
		.rst(rst),
		.pix_en(pix_en),
		.hcount(hcount),
		.vcount(vcount),
		.hblank_n(hblank_n),
		.hsync_n(hsync_n),
		.vblank_n(vblank_n),
		.vsync_n(vsync_n)
	);

	timing_control ctrl0 (
		.CLK_48M(CLK_48M),
		.rst(rst),
		.pix_en(pix_en),
		.hcount(hcount),
		.vcount(vcount),
		.hblank_n(hblank_n),
		.hsync_n(hsync_n),
		.vblank_n(vblank_n),
		.vsync_n(vsync_n),
		.n_hsync(n_hsync),
		.n_vsync(n_vsync),
		.n_hblank(n_hblank),
		.n_vblank(n_vblank),
		.n_hreset(n_hreset),
		.n_vreset(n_vreset),
		.clk_1h(clk_1h),
		.clk_s1h(clk_s1h),
		.clk_2h(clk_2h),
		.clk_s2h(clk_s2h),
		.clk_4h(clk_4h),
		.clk_1v(clk_1v),
		.clk_4v(clk_4v),
		.clk_8v(clk_8v)
	);

endmodule

`default_nettype wire

// ==== bench/video_timing_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_timing_props (
	input wire CLK_48M,
	input wire rst,
	input wire clk_6m,
	input wire n_hreset,
	input wire n_hsync,
	input wire n_hblank
);

	// Failed assertion count
	int fail_count = 0;

	// 6 MHz level, four master cycles each half
	rise_to_fall: assert property (@(posedge CLK_48M) disable iff (rst)
		$rose(clk_6m) |-> ##4 $fell(clk_6m))
		else begin
			fail_count++;
			$error("clk_6m high phase not 4 cycles");
		end

	fall_to_rise: assert property (@(posedge CLK_48M) disable iff (rst)
		$fell(clk_6m) |-> ##4 $rose(clk_6m))
		else begin
			fail_count++;
			$error("clk_6m low phase not 4 cycles");
		end

	// Line reset lasts one pixel
	hreset_width: assert property (@(posedge CLK_48M) disable iff (rst)
		$rose(n_hreset) |-> ##8 !n_hreset)
		else begin
			fail_count++;
			$error("n_hreset held past one pixel");
		end

	// Sync nested in blank
	hsync_in_blank: assert property (@(posedge CLK_48M) disable iff (rst)
		!n_hsync |-> !n_hblank)
		else begin
			fail_count++;
			$error("n_hsync low outside horizontal blank");
		end

endmodule

bind video_timing_gen video_timing_props props0 (
	.CLK_48M(CLK_48M),
	.rst(rst),
	.clk_6m(clk_6m),
	.n_hreset(n_hreset),
	.n_hsync(n_hsync),
	.n_hblank(n_hblank)
);

`default_nettype wire

// ==== bench/video_timing_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_params.svh"

module video_timing_tb;

	// Raster size from the shared geometry
	localparam int H_TOTAL = int'(`H_LAST) + 1;
	localparam int V_TOTAL = int'(`V_LAST) + 1;
	// Two frames of master cycles
	localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL * 8;
	localparam int TBL_N = 24;

	logic CLK_48M = 1'b0;
	logic rst;
	wire clk_24m;
	wire clk_12m;
	wire clk_6m;
	wire n_hsync;
	wire n_vsync;
	wire n_hblank;
	wire n_vblank;
	wire n_hreset;
	wire n_vreset;
	wire clk_1h;
	wire clk_s1h;
	wire clk_2h;
	wire clk_s2h;
	wire clk_4h;
	wire clk_1v;
	wire clk_4v;
	wire clk_8v;

	// Reference model state
	int unsigned cyc;
	int pix_total;

	// Sample points in time order
	string name_q[$];
	int idx_q[$];

	//////////////////////////////
	// Sample table
	//////////////////////////////

	string tbl_name [TBL_N] = '{
		"hreset_before", "hreset_pixel", "hreset_after", "hblank_before",
		"hblank_start", "hsync_before", "hsync_start", "hsync_last",
		"hsync_end", "hblank_last", "hblank_end", "line_end",
		"vblank_before", "vblank_start", "vsync_before", "vsync_start",
		"frame_end", "frame_wrap", "vreset_before", "vreset_pixel",
		"vreset_after", "vreset_next_line", "vblank_last", "vblank_end"};
	// Frame then line then pixel of each named point
	int tbl_pos [TBL_N][3] = '{
		'{1, 100, 14}, '{1, 100, 15}, '{1, 100, 16}, '{1, 100, 271},
		'{1, 100, 272}, '{1, 100, 303}, '{1, 100, 304}, '{1, 100, 335},
		'{1, 100, 336}, '{1, 100, 367}, '{1, 100, 368}, '{1, 100, 383},
		'{1, 239, 0}, '{1, 240, 0}, '{1, 247, 100}, '{1, 248, 0},
		'{1, 263, 383}, '{2, 0, 0}, '{2, 0, 303}, '{2, 0, 304},
		'{2, 0, 305}, '{2, 1, 304}, '{2, 15, 15}, '{2, 16, 0}};

	video_timing_gen dut0 (.*);

	always #20 CLK_48M = ~CLK_48M;

	// Cycle count and pixel count since rst fell
	always @(posedge CLK_48M) begin
		if (rst) begin
			cyc <= 0;
			pix_total <= 0;
		end else begin
			cyc <= cyc + 1;
			if (cyc % 8 == 7) begin
				pix_total <= pix_total + 1;
			end
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string test, input string sig, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("mismatch %s %s expected %0b actual %0b",
				test, sig, expected, actual));
		end
	endtask

	// Keeps the list ordered by absolute pixel index
	task automatic add_point(input string name, input int frame, input int line,
			input int pixel);
		int idx;
		int pos;
		idx = (frame * V_TOTAL + line) * H_TOTAL + pixel;
		pos = 0;
		while (pos < idx_q.size() && idx_q[pos] <= idx) begin
			pos++;
		end
		name_q.insert(pos, name);
		idx_q.insert(pos, idx);
	endtask

	// Stage n means n pixel enables seen so far
	task automatic wait_stage(input int stage, input string test);
		int guard;
		guard = 0;
		while (pix_total < stage) begin
			@(posedge CLK_48M);
			#1;
			guard++;
			if (guard > WAIT_LIMIT) begin
				stop_on_error({"timeout while waiting for sample point ", test});
			end
		end
		if (pix_total != stage) begin
			stop_on_error({"sample point ", test, " was already passed"});
		end
	endtask

	task automatic check_point(input string name, input int idx);
		video_timing_pkg::hcount_t h;
		video_timing_pkg::vcount_t v;
		h = video_timing_pkg::hcount_t'(idx % H_TOTAL);
		v = video_timing_pkg::vcount_t'((idx / H_TOTAL) % V_TOTAL);
		// Taps and strobes lag one pixel
		wait_stage(idx + 1, name);
		check_value(name, "n_hreset", h == `HRESET_POS, n_hreset);
		check_value(name, "n_vreset", v == 9'd0 && h == `VRESET_POS, n_vreset);
		check_value(name, "clk_1h", h[0], clk_1h);
		check_value(name, "clk_s1h", h[0], clk_s1h);
		check_value(name, "clk_2h", h[1], clk_2h);
		check_value(name, "clk_s2h", h[1], clk_s2h);
		check_value(name, "clk_4h", h[2], clk_4h);
		check_value(name, "clk_1v", v[0], clk_1v);
		check_value(name, "clk_4v", v[3], clk_4v);
		check_value(name, "clk_8v", v[7], clk_8v);
		// Sync and blank lag two pixels
		wait_stage(idx + 2, name);
		check_value(name, "n_hblank", !(h >= `HBLANK_START && h < `HBLANK_END), n_hblank);
		check_value(name, "n_hsync", !(h >= `HSYNC_START && h < `HSYNC_END), n_hsync);
		check_value(name, "n_vblank", !(v >= `VBLANK_START || v < `VBLANK_END), n_vblank);
		check_value(name, "n_vsync", !(v >= `VSYNC_START), n_vsync);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int i;
		rst = 1'b1;
		void'($urandom(84));
		repeat (4) @(posedge CLK_48M);
		#1;
		// Reset values
		check_value("reset_state", "n_hsync", 1'b1, n_hsync);
		check_value("reset_state", "n_vsync", 1'b1, n_vsync);
		check_value("reset_state", "n_hblank", 1'b1, n_hblank);
		check_value("reset_state", "n_vblank", 1'b1, n_vblank);
		check_value("reset_state", "n_hreset", 1'b0, n_hreset);
		check_value("reset_state", "n_vreset", 1'b0, n_vreset);
		check_value("reset_state", "clk_1h", 1'b0, clk_1h);
		check_value("reset_state", "clk_s1h", 1'b0, clk_s1h);
		check_value("reset_state", "clk_2h", 1'b0, clk_2h);
		check_value("reset_state", "clk_s2h", 1'b0, clk_s2h);
		check_value("reset_state", "clk_4h", 1'b0, clk_4h);
		check_value("reset_state", "clk_1v", 1'b0, clk_1v);
		check_value("reset_state", "clk_4v", 1'b0, clk_4v);
		check_value("reset_state", "clk_8v", 1'b0, clk_8v);
		check_value("reset_state", "clk_24m", 1'b0, clk_24m);
		check_value("reset_state", "clk_12m", 1'b0, clk_12m);
		check_value("reset_state", "clk_6m", 1'b0, clk_6m);
		rst = 1'b0;
		// Divider levels follow the cycle count
		for (i = 0; i < 32; i++) begin
			check_value("clock_levels", "clk_24m", cyc[0], clk_24m);
			check_value("clock_levels", "clk_12m", cyc[1], clk_12m);
			check_value("clock_levels", "clk_6m", cyc[2], clk_6m);
			@(posedge CLK_48M);
			#1;
		end
		for (i = 0; i < TBL_N; i++) begin
			add_point(tbl_name[i], tbl_pos[i][0], tbl_pos[i][1], tbl_pos[i][2]);
		end
		// Random taps in frame one away from the fixed lines
		for (i = 0; i < 20; i++) begin
			add_point($sformatf("random_%0d", i), 1, 110 + 6 * i + int'($urandom % 6),
				int'($urandom % H_TOTAL));
		end
		for (i = 0; i < idx_q.size(); i++) begin
			check_point(name_q[i], idx_q[i]);
		end
		if (dut0.props0.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			stop_on_error("property checks on the DUT reported failures");
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/video_timing_pkg.sv
verilog/clock_enable_gen.sv
verilog/raster_counter.sv
verilog/sync_decoder.sv
verilog/timing_control.sv
verilog/video_timing_gen.sv
bench/video_timing_props.sv
bench/video_timing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the raster timing testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 -f filelist.f \
	--top-module video_timing_tb -o video_timing_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/video_timing_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
